// File: hdl/robots_cfg.svh
/* Field geometry, scan timing, robot density, dump framing and PRNG constants.
   The geometry values must stay powers of two in the column direction. */
`ifndef ROBOTS_CFG_SVH
`define ROBOTS_CFG_SVH

// tile map geometry, one byte holds two stacked cells
`define ROBOTS_COLS 128
`define ROBOTS_ROW_PAIRS 48
// columns from here to the right edge hold the score area
`define ROBOTS_SCORE_COL 7'd120

// clocks spent on each byte of the scan
`define ROBOTS_PHASES 5

// robot probability added per level, units of 1/65536
`define ROBOT_PROB_STEP 12'd171
// player start column must stay left of the score area
`define PLAYER_X_LIMIT 7'd120
// player start row is this plus 0..63
`define PLAYER_Y_BASE 7'd16

// serial dump frame markers
`define DUMP_MARK_START 8'h23
`define DUMP_MARK_ROW 8'h24
`define DUMP_MARK_ROW_END 8'h25
`define DUMP_MARK_END 8'h26
// upper nibble of every dumped data byte
`define DUMP_DATA_TAG 4'h3

// 29-bit galois LFSR, x^29 + x^27 + 1
`define PRNG_SEED 29'd1
`define PRNG_TAPS 29'h1400_0000

`endif

// File: hdl/robots_field_pkg.sv
/* Tile map and cell types. Address is the row pair above the column,
   so the map is 48 rows of 128 bytes packed with no gaps. */
`default_nettype none

package robots_field_pkg;

    // contents of one playing field cell
    typedef enum logic [1:0] {
        cell_empty  = 2'd0,
        cell_robot  = 2'd1,
        cell_trash  = 2'd2,
        cell_player = 2'd3
    } cell_t;

    typedef logic [12:0] tile_addr_t;
    // low nibble visible: bits 1:0 upper cell, bits 3:2 lower cell
    typedef logic [7:0] tile_byte_t;
    typedef logic [6:0] col_t;
    typedef logic [5:0] row_pair_t;

    // byte address of a scan position
    function automatic tile_addr_t tile_addr(input row_pair_t y, input col_t x);
        return {y, x};
    endfunction

endpackage

`default_nettype wire

// File: hdl/robots_ctrl_pkg.sv
/* Scan control types. Opcode encodings are internal and may be renumbered
   freely; only the order of the pass sequence matters. */
`default_nettype none

package robots_ctrl_pkg;

    // one opcode runs for a whole pass over the tile map
    typedef enum logic [2:0] {
        opc_boot      = 3'd0,
        opc_idle      = 3'd1,
        opc_new_game  = 3'd2,
        opc_new_level = 3'd3,
        opc_dump      = 3'd4
    } opcode_t;

    // clock within the current byte, 0 to 4
    typedef logic [2:0] phase_t;

endpackage

`default_nettype wire

// File: hdl/tile_map_ram.sv
/* Single-port tile map RAM, read data one clock after the address.
   A write returns the old byte on the same cycle. Contents undefined until filled. */
`default_nettype none

`include "robots_cfg.svh"

module tile_map_ram (
    input  logic                         clk,
    input  robots_field_pkg::tile_addr_t addr,
    input  logic                         wen,
    input  robots_field_pkg::tile_byte_t wdata,
    output robots_field_pkg::tile_byte_t rdata
);

    localparam int depth = `ROBOTS_COLS * `ROBOTS_ROW_PAIRS;

    robots_field_pkg::tile_byte_t mem [depth];

    // read before write
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: hdl/tile_arbiter.sv
/* Shares the RAM port between the level filler and the field dumper.
   Filler has priority; only the filler may write. Idle port reads address 0. */
`default_nettype none

module tile_arbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fill_req,
    input  logic                         fill_wen,
    input  robots_field_pkg::tile_addr_t fill_addr,
    input  robots_field_pkg::tile_byte_t fill_wdata,
    input  logic                         dump_req,
    input  robots_field_pkg::tile_addr_t dump_addr,
    output robots_field_pkg::tile_addr_t ram_addr,
    output logic                         ram_wen,
    output robots_field_pkg::tile_byte_t ram_wdata
);

    logic fill_grant;
    logic dump_grant;

    // filler first
    assign fill_grant = fill_req;
    assign dump_grant = dump_req && !fill_req;

    assign ram_addr = fill_grant ? fill_addr :
                      dump_grant ? dump_addr : '0;
    // writes without the grant never reach the RAM
    assign ram_wen   = fill_grant && fill_wen;
    assign ram_wdata = fill_wdata;

    // each engine requests only during its own opcode
    a_req_exclusive : assert property (@(posedge clk) disable iff (rst)
        !(fill_req && dump_req));

    // the filler holds the port for a while before its first write of a byte
    a_wen_granted : assert property (@(posedge clk) disable iff (rst)
        $rose(ram_wen) |-> $past(fill_grant));

endmodule

`default_nettype wire

// File: hdl/scan_sequencer.sv
/* Walks the tile map in reverse, five clocks per byte, one opcode per pass.
   Commands are pulses, latched until taken in idle. Suspend freezes the scan. */
`default_nettype none

`include "robots_cfg.svh"

module scan_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_new_level,
    input  logic                        cmd_new_game,
    input  logic                        dump_start,
    input  logic                        suspend,
    output robots_ctrl_pkg::opcode_t    opcode,
    output robots_field_pkg::col_t      x,
    output robots_field_pkg::row_pair_t y,
    output robots_ctrl_pkg::phase_t     phase,
    output logic                        fill_start,
    output logic                        game_restart
);

    localparam robots_field_pkg::col_t x_first =
        robots_field_pkg::col_t'(`ROBOTS_COLS - 1);
    localparam robots_field_pkg::row_pair_t y_first =
        robots_field_pkg::row_pair_t'(`ROBOTS_ROW_PAIRS - 1);
    localparam robots_ctrl_pkg::phase_t phase_last =
        robots_ctrl_pkg::phase_t'(`ROBOTS_PHASES - 1);

    logic pend_level, pend_game, pend_dump;
    logic take_level, take_game, take_dump;
    logic last_phase, last_byte, advance_op;
    robots_ctrl_pkg::opcode_t opcode_next;

    assign last_phase = (phase == phase_last);
    assign last_byte  = last_phase && (x == '0) && (y == '0);
    // idle switches on any cycle, other opcodes at the end of their pass
    assign advance_op = !suspend && ((opcode == robots_ctrl_pkg::opc_idle) || last_byte);

    always_comb begin
        opcode_next = robots_ctrl_pkg::opc_idle;
        take_level  = 1'b0;
        take_game   = 1'b0;
        take_dump   = 1'b0;
        case (opcode)
            robots_ctrl_pkg::opc_idle: begin
                // new level, then new game, then dump
                if (pend_level) begin
                    take_level  = 1'b1;
                    opcode_next = robots_ctrl_pkg::opc_new_level;
                end else if (pend_game) begin
                    take_game   = 1'b1;
                    opcode_next = robots_ctrl_pkg::opc_new_game;
                end else if (pend_dump) begin
                    take_dump   = 1'b1;
                    opcode_next = robots_ctrl_pkg::opc_dump;
                end
            end
            robots_ctrl_pkg::opc_boot:     opcode_next = robots_ctrl_pkg::opc_new_game;
            robots_ctrl_pkg::opc_new_game: opcode_next = robots_ctrl_pkg::opc_new_level;
            default:                       opcode_next = robots_ctrl_pkg::opc_idle;
        endcase
    end

    // filler advances level and player on entry to new_level
    assign fill_start   = advance_op && (opcode_next == robots_ctrl_pkg::opc_new_level);
    assign game_restart = advance_op && take_game;

    always_ff @(posedge clk) begin
        if (rst) begin
            opcode     <= robots_ctrl_pkg::opc_boot;
            x          <= x_first;
            y          <= y_first;
            phase      <= '0;
            pend_level <= 1'b0;
            pend_game  <= 1'b0;
            pend_dump  <= 1'b0;
        end else begin
            // a new pulse wins over a clear on the same cycle
            pend_level <= (pend_level && !(take_level && advance_op)) || cmd_new_level;
            pend_game  <= (pend_game && !(take_game && advance_op)) || cmd_new_game;
            pend_dump  <= (pend_dump && !(take_dump && advance_op)) || dump_start;
            if (advance_op) begin
                opcode <= opcode_next;
                x      <= x_first;
                y      <= y_first;
                phase  <= '0;
            end else if (!suspend) begin
                if (!last_phase) begin
                    phase <= phase + 3'd1;
                end else begin
                    phase <= '0;
                    if (x != '0) begin
                        x <= x - 7'd1;
                    end else begin
                        x <= x_first;
                        y <= y - 6'd1;
                    end
                end
            end
        end
    end

    a_phase_range : assert property (@(posedge clk) disable iff (rst)
        phase < robots_ctrl_pkg::phase_t'(`ROBOTS_PHASES));

endmodule

`default_nettype wire

// File: hdl/level_fill.sv
/* Clears the play area and places robots and one player for a new level.
   Robot count is only statistical. Score columns are written as zero. */
`default_nettype none

`include "robots_cfg.svh"

module level_fill (
    input  logic                         clk,
    input  logic                         rst,
    input  robots_ctrl_pkg::opcode_t     opcode,
    input  robots_field_pkg::col_t       x,
    input  robots_field_pkg::row_pair_t  y,
    input  robots_ctrl_pkg::phase_t      phase,
    input  logic                         fill_start,
    input  logic                         game_restart,
    input  robots_field_pkg::tile_byte_t rdata,
    output logic                         req,
    output logic                         wen,
    output robots_field_pkg::tile_addr_t addr,
    output robots_field_pkg::tile_byte_t wdata
);

    logic [28:0] prng_st;
    logic [15:0] prng;
    logic [11:0] robot_prob;
    logic [6:0] player_x, player_y;
    logic [6:0] new_player_x, new_player_y;
    logic place_robot, robot_upper, player_pair, in_score;
    robots_field_pkg::cell_t cell_upper, cell_lower;

    // eight galois shifts per clock
    function automatic logic [28:0] lfsr_step8(input logic [28:0] s);
        logic [28:0] v;
        v = s;
        for (int i = 0; i < 8; i++) begin
            v = v[0] ? ((v >> 1) ^ `PRNG_TAPS) : (v >> 1);
        end
        return v;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            prng_st <= `PRNG_SEED;
        end else begin
            prng_st <= lfsr_step8(prng_st);
        end
    end

    // newest two clocks of output
    assign prng = prng_st[15:0];

    // robot density rises per level, top bit kept clear so it never wraps to zero
    always_ff @(posedge clk) begin
        if (rst || game_restart) begin
            robot_prob <= '0;
        end else if (fill_start) begin
            robot_prob <= {1'b0, robot_prob[10:0]} + `ROBOT_PROB_STEP;
        end
    end

    assign place_robot = (prng < {4'd0, robot_prob});

    // player column 0..119, fall back to mid field; row 16..79
    assign new_player_x = (prng[12:6] < `PLAYER_X_LIMIT) ? prng[12:6] : (`PLAYER_X_LIMIT >> 1);
    assign new_player_y = {1'b0, prng[5:0]} + `PLAYER_Y_BASE;

    always_ff @(posedge clk) begin
        if (rst) begin
            player_x <= '0;
            player_y <= '0;
        end else if (fill_start) begin
            player_x <= new_player_x;
            player_y <= new_player_y;
        end
    end

    // upper cell decided in phase 0, lower one at write time
    always_ff @(posedge clk) begin
        if (phase == '0) begin
            robot_upper <= place_robot;
        end
    end

    assign player_pair = (x == player_x) && (y == player_y[6:1]);
    assign in_score    = (x >= `ROBOTS_SCORE_COL);

    always_comb begin
        if (player_pair && !player_y[0]) begin
            cell_upper = robots_field_pkg::cell_player;
        end else begin
            cell_upper = robot_upper ? robots_field_pkg::cell_robot : robots_field_pkg::cell_empty;
        end
        if (player_pair && player_y[0]) begin
            cell_lower = robots_field_pkg::cell_player;
        end else begin
            cell_lower = place_robot ? robots_field_pkg::cell_robot : robots_field_pkg::cell_empty;
        end
    end

    assign req   = (opcode == robots_ctrl_pkg::opc_new_level);
    assign addr  = robots_field_pkg::tile_addr(y, x);
    assign wen   = req && (phase == 3'd3);
    assign wdata = in_score ? 8'h00 : {4'h0, cell_lower, cell_upper};

    // the byte written reads back through arbiter and RAM two clocks later
    a_readback : assert property (@(posedge clk) disable iff (rst)
        wen |=> ##1 (rdata == $past(wdata, 2)));

endmodule

`default_nettype wire

// File: hdl/field_dump.sv
/* Streams the tile map over the serial strobe/ready port with frame markers.
   Pause or a busy transmitter freezes the scan, so no byte is dropped. */
`default_nettype none

`include "robots_cfg.svh"

module field_dump (
    input  robots_ctrl_pkg::opcode_t     opcode,
    input  robots_field_pkg::col_t       x,
    input  robots_field_pkg::row_pair_t  y,
    input  robots_ctrl_pkg::phase_t      phase,
    input  robots_field_pkg::tile_byte_t rdata,
    input  logic                         dump_pause,
    input  logic                         ser_tx_rdy,
    output logic                         req,
    output robots_field_pkg::tile_addr_t addr,
    output logic                         suspend,
    output logic [7:0]                   ser_tx_dat,
    output logic                         ser_tx_stb
);

    logic x_first, y_first, x_last, y_last;
    logic emit;

    assign x_first = (x == robots_field_pkg::col_t'(`ROBOTS_COLS - 1));
    assign y_first = (y == robots_field_pkg::row_pair_t'(`ROBOTS_ROW_PAIRS - 1));
    assign x_last  = (x == '0);
    assign y_last  = (y == '0);

    // what goes out in each phase of a byte
    always_comb begin
        emit       = 1'b0;
        ser_tx_dat = 8'h00;
        case (phase)
            3'd0: if (x_first && y_first) begin
                emit       = 1'b1;
                ser_tx_dat = `DUMP_MARK_START;
            end
            3'd1: if (x_first) begin
                emit       = 1'b1;
                ser_tx_dat = `DUMP_MARK_ROW;
            end
            // read data for this byte is valid from phase 1 on
            3'd2: begin
                emit       = 1'b1;
                ser_tx_dat = {`DUMP_DATA_TAG, rdata[3:0]};
            end
            3'd3: if (x_last) begin
                emit       = 1'b1;
                ser_tx_dat = `DUMP_MARK_ROW_END;
            end
            3'd4: if (x_last && y_last) begin
                emit       = 1'b1;
                ser_tx_dat = `DUMP_MARK_END;
            end
            default: emit = 1'b0;
        endcase
    end

    assign req  = (opcode == robots_ctrl_pkg::opc_dump);
    assign addr = robots_field_pkg::tile_addr(y, x);

    // hold every phase, not only emitting ones, until the port is free
    assign suspend    = req && (dump_pause || !ser_tx_rdy);
    assign ser_tx_stb = req && emit && ser_tx_rdy && !dump_pause;

endmodule

`default_nettype wire

// File: hdl/robots_play_top.sv
/* Scanning core of the robots game: sequencer, level filler, field dumper,
   RAM arbiter and tile map RAM. Command inputs are single-cycle pulses. */
`default_nettype none

module robots_play_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_new_level,
    input  logic       cmd_new_game,
    input  logic       dump_start,
    input  logic       dump_pause,
    input  logic       ser_tx_rdy,
    output logic [7:0] ser_tx_dat,
    output logic       ser_tx_stb
);

    robots_ctrl_pkg::opcode_t     opcode;
    robots_field_pkg::col_t       x;
    robots_field_pkg::row_pair_t  y;
    robots_ctrl_pkg::phase_t      phase;
    logic                         fill_start, game_restart, suspend;
    logic                         fill_req, fill_wen, dump_req, ram_wen;
    robots_field_pkg::tile_addr_t fill_addr, dump_addr, ram_addr;
    robots_field_pkg::tile_byte_t fill_wdata, ram_wdata, ram_rdata;

    scan_sequencer u_scan_sequencer (
        .clk, .rst, .cmd_new_level, .cmd_new_game, .dump_start, .suspend,
        .opcode, .x, .y, .phase, .fill_start, .game_restart
    );

    // both engines see the same read data
    level_fill u_level_fill (
        .clk, .rst, .opcode, .x, .y, .phase, .fill_start, .game_restart,
        .rdata(ram_rdata), .req(fill_req), .wen(fill_wen),
        .addr(fill_addr), .wdata(fill_wdata)
    );

    field_dump u_field_dump (
        .opcode, .x, .y, .phase, .rdata(ram_rdata), .dump_pause, .ser_tx_rdy,
        .req(dump_req), .addr(dump_addr), .suspend, .ser_tx_dat, .ser_tx_stb
    );

    tile_arbiter u_tile_arbiter (
        .clk, .rst, .fill_req, .fill_wen, .fill_addr, .fill_wdata,
        .dump_req, .dump_addr, .ram_addr, .ram_wen, .ram_wdata
    );

    tile_map_ram u_tile_map_ram (
        .clk, .addr(ram_addr), .wen(ram_wen), .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// File: sim/dump_checker.sv
/* Watches the top-level ports of the robots core and checks every serial dump.
   Needs a full frame per dump; an error raises check_failed for the testbench. */
`default_nettype none

`include "robots_cfg.svh"

module dump_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_new_level,
    input  logic       cmd_new_game,
    input  logic       dump_start,
    input  logic       dump_pause,
    input  logic       ser_tx_rdy,
    input  logic [7:0] ser_tx_dat,
    input  logic       ser_tx_stb,
    output logic       check_failed,
    output int         dumps_done
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int pass_cycles = `ROBOTS_COLS * `ROBOTS_ROW_PAIRS * `ROBOTS_PHASES;
    // data bytes per row that belong to the score columns
    localparam int score_bytes = `ROBOTS_COLS - int'(`ROBOTS_SCORE_COL);
    localparam logic [1:0] exp_row = 2'd0;
    localparam logic [1:0] exp_data = 2'd1;
    localparam logic [1:0] exp_row_end = 2'd2;
    localparam logic [1:0] exp_end = 2'd3;

    logic err_quiet = 1'b0;
    logic err_legal = 1'b0;
    logic err_frame = 1'b0;
    logic err_order = 1'b0;
    logic dump_seen;
    logic in_frame;
    logic [1:0] expect_kind;
    int row_count;
    int col_count;
    int player_count;
    // lower bound on cycles until the pending fill is over
    int fill_left;

    assign check_failed = err_quiet || err_legal || err_frame || err_order;

    function automatic void print_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
    endfunction

    // player cells in one dumped byte, upper and lower
    function automatic int player_cells(input logic [7:0] b);
        return int'(b[1:0] == robots_field_pkg::cell_player)
             + int'(b[3:2] == robots_field_pkg::cell_player);
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            dump_seen <= 1'b0;
        end else if (dump_start) begin
            dump_seen <= 1'b1;
        end
    end

    a_quiet_before_dump : assert property (@(posedge clk) disable iff (rst)
        !dump_seen |-> !ser_tx_stb)
        else begin
            print_error("serial strobe before any dump request");
            err_quiet <= 1'b1;
        end

    a_strobe_legal : assert property (@(posedge clk) disable iff (rst)
        ser_tx_stb |-> ser_tx_rdy && !dump_pause)
        else begin
            print_error("serial strobe while transmitter busy or dump paused");
            err_legal <= 1'b1;
        end

    // frame walk: start, rows of marker/data/marker, end
    always @(posedge clk) begin
        if (rst) begin
            in_frame     <= 1'b0;
            expect_kind  <= exp_row;
            row_count    <= 0;
            col_count    <= 0;
            player_count <= 0;
            dumps_done   <= 0;
        end else if (ser_tx_stb) begin
            if (!in_frame) begin
                a_start_mark : assert (ser_tx_dat == `DUMP_MARK_START)
                    else begin
                        print_error($sformatf("start marker expected, got %h", ser_tx_dat));
                        err_frame <= 1'b1;
                    end
                in_frame     <= 1'b1;
                expect_kind  <= exp_row;
                row_count    <= 0;
                player_count <= 0;
            end else begin
                case (expect_kind)
                    exp_row: begin
                        a_row_mark : assert (ser_tx_dat == `DUMP_MARK_ROW)
                            else begin
                                print_error($sformatf("row %0d marker wrong, got %h",
                                    row_count, ser_tx_dat));
                                err_frame <= 1'b1;
                            end
                        col_count   <= 0;
                        expect_kind <= exp_data;
                    end
                    exp_data: begin
                        a_data_range : assert (ser_tx_dat >= 8'h30 && ser_tx_dat <= 8'h3F)
                            else begin
                                print_error($sformatf("data byte %h out of range", ser_tx_dat));
                                err_frame <= 1'b1;
                            end
                        // score area is dumped first, columns 127 down to 120
                        a_score_zero : assert (col_count >= score_bytes || ser_tx_dat == 8'h30)
                            else begin
                                print_error($sformatf("score byte %0d of row %0d is %h",
                                    col_count, row_count, ser_tx_dat));
                                err_frame <= 1'b1;
                            end
                        a_no_trash : assert (ser_tx_dat[1:0] != robots_field_pkg::cell_trash
                                && ser_tx_dat[3:2] != robots_field_pkg::cell_trash)
                            else begin
                                print_error($sformatf("trash cell in byte %h", ser_tx_dat));
                                err_frame <= 1'b1;
                            end
                        player_count <= player_count + player_cells(ser_tx_dat);
                        col_count    <= col_count + 1;
                        if (col_count == `ROBOTS_COLS - 1) begin
                            expect_kind <= exp_row_end;
                        end
                    end
                    exp_row_end: begin
                        a_row_end_mark : assert (ser_tx_dat == `DUMP_MARK_ROW_END)
                            else begin
                                print_error($sformatf("row end marker expected, got %h",
                                    ser_tx_dat));
                                err_frame <= 1'b1;
                            end
                        row_count   <= row_count + 1;
                        expect_kind <= (row_count == `ROBOTS_ROW_PAIRS - 1) ? exp_end : exp_row;
                    end
                    default: begin
                        a_end_mark : assert (ser_tx_dat == `DUMP_MARK_END)
                            else begin
                                print_error($sformatf("end marker expected, got %h",
                                    ser_tx_dat));
                                err_frame <= 1'b1;
                            end
                        a_one_player : assert (player_count == 1)
                            else begin
                                print_error($sformatf("dump holds %0d player cells",
                                    player_count));
                                err_frame <= 1'b1;
                            end
                        in_frame   <= 1'b0;
                        dumps_done <= dumps_done + 1;
                    end
                endcase
            end
        end
    end

    // a dump may only open once every requested fill pass has run
    always @(posedge clk) begin : track_fill
        int left_next;
        left_next = (fill_left > 0) ? fill_left - 1 : 0;
        // new game runs the new_game pass and then a new_level pass
        if (cmd_new_game && left_next < 2 * pass_cycles) begin
            left_next = 2 * pass_cycles;
        end
        if (cmd_new_level && left_next < pass_cycles) begin
            left_next = pass_cycles;
        end
        if (rst) begin
            // boot, new_game and new_level passes follow reset
            fill_left <= 3 * pass_cycles;
        end else begin
            fill_left <= left_next;
            if (ser_tx_stb && !in_frame) begin
                a_fill_before_dump : assert (fill_left == 0)
                    else begin
                        print_error($sformatf("dump opened %0d cycles before fill end",
                            fill_left));
                        err_order <= 1'b1;
                    end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/robots_tb.sv
/* Testbench for the robots scanning core. Runs three fills and three dumps
   against a random serial transmitter; all checking sits in dump_checker. */
`default_nettype none

`include "robots_cfg.svh"

module robots_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int pass_cycles = `ROBOTS_COLS * `ROBOTS_ROW_PAIRS * `ROBOTS_PHASES;
    // twelve passes, tripled to leave room for suspended dump cycles
    localparam int timeout_cycles = 12 * pass_cycles * 3;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic cmd_new_level = 1'b0;
    logic cmd_new_game = 1'b0;
    logic dump_start = 1'b0;
    logic dump_pause = 1'b0;
    logic ser_tx_rdy = 1'b1;
    logic [7:0] ser_tx_dat;
    logic ser_tx_stb;
    logic check_failed;
    int dumps_done;
    int busy_left = 0;
    int cycle_count = 0;

    always #10 clk = ~clk;

    robots_play_top u_robots_play_top (
        .clk, .rst, .cmd_new_level, .cmd_new_game, .dump_start, .dump_pause,
        .ser_tx_rdy, .ser_tx_dat, .ser_tx_stb
    );

    dump_checker u_dump_checker (
        .clk, .rst, .cmd_new_level, .cmd_new_game, .dump_start, .dump_pause,
        .ser_tx_rdy, .ser_tx_dat, .ser_tx_stb, .check_failed, .dumps_done
    );

    // transmitter stays busy 1 to 4 cycles after each byte
    always @(posedge clk) begin
        if (rst) begin
            ser_tx_rdy <= 1'b1;
            busy_left  <= 0;
        end else if (ser_tx_stb) begin
            ser_tx_rdy <= 1'b0;
            busy_left  <= $urandom_range(4, 1);
        end else if (busy_left > 1) begin
            busy_left <= busy_left - 1;
        end else if (busy_left == 1) begin
            busy_left  <= 0;
            ser_tx_rdy <= 1'b1;
        end
    end

    // pause roughly one cycle in eight
    always @(posedge clk) begin
        if (rst) begin
            dump_pause <= 1'b0;
        end else begin
            dump_pause <= ($urandom % 8) == 0;
        end
    end

    always @(posedge clk) begin
        if (check_failed) begin
            $display("*** FAILED ***");
            $fatal(1, "dump checker reported an error");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: three dumps not finished within %0d cycles", timeout_cycles);
            $display("*** FAILED ***");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic press_new_level();
        @(posedge clk);
        cmd_new_level <= 1'b1;
        @(posedge clk);
        cmd_new_level <= 1'b0;
    endtask

    task automatic press_new_game();
        @(posedge clk);
        cmd_new_game <= 1'b1;
        @(posedge clk);
        cmd_new_game <= 1'b0;
    endtask

    task automatic request_dump();
        @(posedge clk);
        dump_start <= 1'b1;
        @(posedge clk);
        dump_start <= 1'b0;
    endtask

    task automatic wait_for_dumps(input int count);
        while (dumps_done < count) begin
            @(posedge clk);
        end
    endtask

    initial begin
        void'($urandom(32'h85748cb4));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // level and dump both latched while the boot passes run
        press_new_level();
        request_dump();
        wait_for_dumps(1);
        // dump requested in the middle of the new game fill
        press_new_game();
        repeat (5000) @(posedge clk);
        request_dump();
        wait_for_dumps(2);
        // next level, dump asked for at a random point of its fill
        press_new_level();
        repeat ($urandom_range(20000, 1000)) @(posedge clk);
        request_dump();
        wait_for_dumps(3);
        repeat (10) @(posedge clk);
        if (check_failed) begin
            $display("*** FAILED ***");
            $fatal(1, "dump checker reported an error");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/robots_field_pkg.sv
hdl/robots_ctrl_pkg.sv
hdl/tile_map_ram.sv
hdl/tile_arbiter.sv
hdl/scan_sequencer.sv
hdl/level_fill.sv
hdl/field_dump.sv
hdl/robots_play_top.sv
sim/dump_checker.sv
sim/robots_tb.sv

// File: Makefile
# Verilator build and run for the robots scanning core testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = robots_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
